// File: verilog/fe_pkg.sv
package fe_pkg;

	// Widths of the datapath seen by the front end
	localparam int pc_size = 32;      // Byte address of an instruction
	localparam int instr_size = 32;   // One fetched instruction word
	localparam int opcode_size = 6;   // Opcode field, bits 31 to 26 of the word

	// Opcodes the front end cares about, everything else behaves as op_alu
	typedef enum logic [opcode_size-1:0] {
		op_alu = 6'h00,               // Plain instruction with no effect on the PC
		op_jal = 6'h03,               // Jump and link, 26-bit signed word offset
		op_br = 6'h04,                // Conditional branch on one of four flags
		op_jr = 6'h12,                // Return through the link register
		op_nop = 6'h15                // Explicit no operation
	} opcode_t;

	// Two-bit saturating counter per BPU entry
	// The upper bit is the taken prediction
	typedef enum logic [1:0] {
		strong_nt = 2'b00,            // Strongly not taken
		weak_nt = 2'b01,              // Weakly not taken, the state after reset
		weak_t = 2'b10,               // Weakly taken
		strong_t = 2'b11              // Strongly taken
	} bctr_t;

	// One slot on the issue port toward the rest of the core
	typedef struct packed {
		logic valid;                  // Slot holds a correct-path instruction
		logic [pc_size-1:0] pc;       // Address the word was fetched from
		logic [instr_size-1:0] instr; // Raw instruction word
	} issue_t;

endpackage

// File: verilog/pc_gen.sv
module pc_gen import fe_pkg::*; (
	input logic clk,                      // Rising edge clock
	input logic nrst,                     // Synchronous reset, active low
	input logic pc_en,                    // Low while the front end is stalled
	input logic mux_sel,                  // Redirect to npc this cycle
	input logic [pc_size-1:0] npc,        // Redirect address from the BPU
	output logic [pc_size-1:0] pc,        // Current fetch address
	output logic [pc_size-1:0] pcplf      // Sequential successor of pc
);

	logic [pc_size-1:0] pc_next;          // Address fetched in the next cycle

	// Sequential successor, one word ahead
	assign pcplf = pc + pc_size'(4);

	// Redirect mux, the BPU decides between its target and the fall-through
	always_comb begin
		if (mux_sel) begin
			pc_next = npc;
		end else begin
			pc_next = pcplf;
		end
	end

	// Fetch starts at address 0 after reset
	always_ff @(posedge clk) begin
		if (!nrst) begin
			pc <= '0;
		end else if (pc_en) begin
			pc <= pc_next;                    // Holds through a stall
		end
	end

endmodule

// File: verilog/bpu.sv
module bpu import fe_pkg::*; #(
	parameter int table_size = 512                     // Entries, must be a power of two
) (
	input logic clk,                                   // Rising edge clock
	input logic nrst,                                  // Synchronous reset, active low
	input opcode_t op,                                 // Opcode of the word being fetched
	input logic [pc_size-1:0] pc,                      // Fetch PC, its low bits index the table
	input logic [pc_size-1:0] alupc,                   // Target computed by the decode adder
	input logic [pc_size-1:0] pcplf,                   // Fetch PC plus 4
	input logic [pc_size-1:0] jr_in,                   // Link register for returns
	input logic jr_bpu,                                // Valid op_jr sits in decode
	input logic pc_en,                                 // Front end advances this cycle
	input logic trgt_gen,                              // Valid op_jal sits in decode
	input logic b_eval,                                // Valid op_br sits in decode
	input logic branch_outcome,                        // Real direction of that branch
	output logic [pc_size-1:0] npc,                    // Redirect address for pc_gen
	output logic chng2nop,                             // Word fetched now is on the wrong path
	output logic mux_sel                               // Take npc instead of PC plus 4
);

	localparam int idx_w = $clog2(table_size);         // Index bits taken from the PC
	localparam int tag_w = pc_size - idx_w - 2;        // Upper PC bits kept as alias tag

	// Prediction tables, one slot per index
	logic [table_size-1:0] valid_tbl;                  // Entry holds a known target
	bctr_t cnt_tbl [table_size];                       // Direction counters
	logic [pc_size-1:0] tgt_tbl [table_size];          // Stored next-PC targets
	logic [tag_w-1:0] tag_tbl [table_size];            // Owner of each entry

	// Fetch-side lookup
	logic [idx_w-1:0] f_idx;                           // Table index of the fetch PC
	logic [tag_w-1:0] f_tag;                           // Tag bits of the fetch PC
	logic f_ctl;                                       // Fetched word is a branch or a jal
	logic f_valid;                                     // Indexed entry is valid
	logic f_alias;                                     // Entry is owned by another PC
	logic f_hit;                                       // Entry belongs to this PC
	logic f_pred;                                      // Redirect the very next fetch

	// Lookup results moved along with the word into decode
	logic valid_pipe;                                  // Entry was valid at fetch
	logic alias_pipe;                                  // Entry was aliased at fetch
	logic pred_pipe;                                   // Fetch went to the stored target
	bctr_t cnt_pipe;                                   // Counter value seen at fetch
	logic [idx_w-1:0] idx_pipe;                        // Index of the decode instruction
	logic [tag_w-1:0] tag_pipe;                        // Tag of the decode instruction
	logic [pc_size-1:0] pcplf_pipe;                    // Fall-through of the decode instruction

	// Decode-side resolution
	logic take_fix;                                    // Taken but fetch went sequential
	logic nt_fix;                                      // Not taken but fetch went to target
	logic fresh_tgt;                                   // First time this target is seen
	logic alias_fix;                                   // Target belongs to an aliasing PC
	logic tgt_wr;                                      // Write target, tag and valid
	bctr_t cnt_next;                                   // Stepped counter for the branch

	assign f_idx = pc[idx_w+1:2];
	assign f_tag = pc[pc_size-1:idx_w+2];
	assign f_ctl = (op == op_br) || (op == op_jal);
	assign f_valid = valid_tbl[f_idx];
	assign f_alias = f_ctl && f_valid && (tag_tbl[f_idx] != f_tag); // Only control words alias
	assign f_hit = f_valid && (tag_tbl[f_idx] == f_tag);
	// A known jal always redirects, a known branch follows its counter
	assign f_pred = f_hit && ((op == op_jal) || ((op == op_br) && cnt_tbl[f_idx][1]));

	// Direction errors, decode inputs arrive already gated by valid and pc_en
	assign take_fix = (trgt_gen || (b_eval && branch_outcome)) && !pred_pipe;
	assign nt_fix = b_eval && !branch_outcome && pred_pipe;
	assign fresh_tgt = (trgt_gen || (b_eval && branch_outcome)) && !valid_pipe;
	assign alias_fix = (trgt_gen || (b_eval && branch_outcome)) && alias_pipe;
	assign tgt_wr = fresh_tgt || alias_fix;            // Both are also covered by take_fix

	assign chng2nop = take_fix || nt_fix || jr_bpu;     // The slot behind a fix is wrong-path
	assign mux_sel = chng2nop || f_pred;

	// Decode fixes win over the fetch-side prediction
	always_comb begin
		if (take_fix) begin
			npc = alupc;                                   // Also the fresh and alias cases
		end else if (nt_fix) begin
			npc = pcplf_pipe;                              // Back to the branch fall-through
		end else if (jr_bpu) begin
			npc = jr_in;                                   // Returns are never predicted
		end else begin
			npc = tgt_tbl[f_idx];                          // Predicted target of the fetch word
		end
	end

	// Counter step, a taken branch that was already predicted taken saturates
	always_comb begin
		if (branch_outcome) begin
			case (cnt_pipe)
				strong_nt: cnt_next = weak_nt;
				weak_nt: cnt_next = weak_t;
				default: cnt_next = strong_t;
			endcase
		end else begin
			case (cnt_pipe)
				strong_t: cnt_next = weak_t;
				weak_t: cnt_next = weak_nt;
				default: cnt_next = strong_nt;
			endcase
		end
	end

	// Validity and counters, updated at the edge that ends decode
	always_ff @(posedge clk) begin
		if (!nrst) begin
			valid_tbl <= '0;
			for (int i = 0; i < table_size; i++) begin
				cnt_tbl[i] <= weak_nt;
			end
		end else begin
			if (tgt_wr) begin
				valid_tbl[idx_pipe] <= 1'b1;
			end
			if (b_eval) begin
				cnt_tbl[idx_pipe] <= cnt_next;
			end
		end
	end

	// Targets and owner tags
	always_ff @(posedge clk) begin
		if (tgt_wr) begin
			tgt_tbl[idx_pipe] <= alupc;
			tag_tbl[idx_pipe] <= tag_pipe;
		end
	end

	// Lookup control moves into decode with the word
	always_ff @(posedge clk) begin
		if (!nrst) begin
			valid_pipe <= 1'b0;
			alias_pipe <= 1'b0;
			pred_pipe <= 1'b0;
		end else if (pc_en) begin
			valid_pipe <= f_valid;
			alias_pipe <= f_alias;
			pred_pipe <= f_pred;
		end
	end

	// Index, tag, counter and fall-through of the same word
	always_ff @(posedge clk) begin
		if (pc_en) begin
			cnt_pipe <= cnt_tbl[f_idx];
			idx_pipe <= f_idx;
			tag_pipe <= f_tag;
			pcplf_pipe <= pcplf;
		end
	end

endmodule

// File: verilog/decode_stage.sv
module decode_stage import fe_pkg::*; (
	input logic clk,                                // Rising edge clock
	input logic nrst,                               // Synchronous reset, active low
	input logic pc_en,                              // Low while the front end is stalled
	input logic chng2nop,                           // Word fetched now must be killed
	input logic [pc_size-1:0] pc,                   // Fetch PC
	input logic [instr_size-1:0] instr,             // Word returned by the instruction memory
	input logic [3:0] cc,                           // Condition flags
	output issue_t issue,                           // Slot offered to the rest of the core
	output logic [pc_size-1:0] alupc,               // Branch or jump target
	output logic [pc_size-1:0] jr_in,               // Link register
	output logic trgt_gen,                          // Valid jal resolved this cycle
	output logic b_eval,                            // Valid branch resolved this cycle
	output logic branch_outcome,                    // Flag picked by the branch condition
	output logic jr_bpu                             // Valid return resolved this cycle
);

	// Fetch to decode pipeline register
	logic d_valid;                                  // Kill bit, low for a wrong-path slot
	logic [pc_size-1:0] d_pc;                       // Address of the decode word
	logic [instr_size-1:0] d_instr;                 // The decode word itself
	logic [pc_size-1:0] link_q;                     // Return address of the last jal

	opcode_t d_op;                                  // Decoded opcode
	logic d_live;                                   // Valid word and the stage advances
	logic [pc_size-1:0] br_off;                     // Branch offset in bytes
	logic [pc_size-1:0] jal_off;                    // Jump offset in bytes
	logic [pc_size-1:0] d_pcplf;                    // Decode PC plus 4

	// Kill bit comes from the BPU verdict on the word being latched
	always_ff @(posedge clk) begin
		if (!nrst) begin
			d_valid <= 1'b0;
		end else if (pc_en) begin
			d_valid <= !chng2nop;
		end
	end

	// Address and word follow the kill bit
	always_ff @(posedge clk) begin
		if (pc_en) begin
			d_pc <= pc;
			d_instr <= instr;
		end
	end

	// Unknown opcodes fall back to op_alu
	always_comb begin
		case (d_instr[instr_size-1 -: opcode_size])
			op_br: d_op = op_br;
			op_jal: d_op = op_jal;
			op_jr: d_op = op_jr;
			op_nop: d_op = op_nop;
			default: d_op = op_alu;
		endcase
	end

	// Word offsets widened to byte offsets
	assign br_off = {{(pc_size-18){d_instr[15]}}, d_instr[15:0], 2'b00};
	assign jal_off = {{(pc_size-28){d_instr[25]}}, d_instr[25:0], 2'b00};
	assign d_pcplf = d_pc + pc_size'(4);
	assign alupc = d_pcplf + ((d_op == op_jal) ? jal_off : br_off);

	// Bits 25..24 pick one of the four flags
	assign branch_outcome = cc[d_instr[25:24]];

	// Effects only for a live slot, never twice across a stall
	assign d_live = d_valid && pc_en;
	assign b_eval = d_live && (d_op == op_br);
	assign trgt_gen = d_live && (d_op == op_jal);
	assign jr_bpu = d_live && (d_op == op_jr);

	// Link register, written by every correct-path jal
	always_ff @(posedge clk) begin
		if (!nrst) begin
			link_q <= '0;
		end else if (trgt_gen) begin
			link_q <= d_pcplf;
		end
	end

	assign jr_in = link_q;
	assign issue = '{valid: d_valid, pc: d_pc, instr: d_instr};

endmodule

// File: verilog/fe_counters.sv
module fe_counters #(
	parameter int cnt_width = 16                   // Width of both counters
) (
	input logic clk,                               // Rising edge clock
	input logic nrst,                              // Synchronous reset, active low
	input logic pc_en,                             // Low while the front end is stalled
	input logic issue_valid,                       // A correct-path word sits on issue
	input logic flush,                             // A fetch slot is being killed
	output logic [cnt_width-1:0] issue_count,      // Words issued so far
	output logic [cnt_width-1:0] flush_count       // Fetch slots thrown away so far
);

	logic [1:0] inc;                               // Count request per counter
	logic [cnt_width-1:0] cnt [2];                 // Counter 0 issues, counter 1 flushes

	assign inc = {flush, issue_valid};

	// Identical saturating counters, one per event
	for (genvar k = 0; k < 2; k++) begin : g_cnt
		always_ff @(posedge clk) begin
			if (!nrst) begin
				cnt[k] <= '0;
			end else if (pc_en && inc[k] && (cnt[k] != '1)) begin
				cnt[k] <= cnt[k] + 1'b1;               // Sticks at all ones
			end
		end
	end

	assign issue_count = cnt[0];
	assign flush_count = cnt[1];

endmodule

// File: verilog/fetch_top.sv
module fetch_top import fe_pkg::*; #(
	parameter int table_size = 512,                  // BPU entries
	parameter int cnt_width = 16                     // Width of the statistics counters
) (
	input logic clk,                                 // Rising edge clock
	input logic nrst,                                // Synchronous reset, active low
	input logic stall,                               // Freezes the whole front end
	output logic [pc_size-1:0] imem_addr,            // Fetch address to the instruction memory
	input logic [instr_size-1:0] imem_data,          // Word returned in the same cycle
	input logic [3:0] cc,                            // Condition flags for branches
	output issue_t issue,                            // Correct-path instruction stream
	output logic [cnt_width-1:0] issue_count,        // Issued instructions
	output logic [cnt_width-1:0] flush_count         // Killed fetch slots
);

	logic pc_en;                                     // Front end advances
	logic [pc_size-1:0] pc;                          // Current fetch PC
	logic [pc_size-1:0] pcplf;                       // Fetch PC plus 4
	logic [pc_size-1:0] npc;                         // Redirect address
	logic mux_sel;                                   // Redirect select
	logic chng2nop;                                  // Kill the word fetched now
	logic [pc_size-1:0] alupc;                       // Decode target
	logic [pc_size-1:0] jr_in;                       // Link register
	logic trgt_gen;                                  // jal resolved in decode
	logic b_eval;                                    // Branch resolved in decode
	logic branch_outcome;                            // Its real direction
	logic jr_bpu;                                    // Return resolved in decode

	assign pc_en = !stall;
	assign imem_addr = pc;

	pc_gen u_pc_gen (
		.clk(clk), .nrst(nrst), .pc_en(pc_en), .mux_sel(mux_sel),
		.npc(npc), .pc(pc), .pcplf(pcplf)
	);

	// The BPU sees the opcode field of the word being fetched
	bpu #(.table_size(table_size)) u_bpu (
		.clk(clk), .nrst(nrst), .op(opcode_t'(imem_data[instr_size-1 -: opcode_size])),
		.pc(pc), .alupc(alupc), .pcplf(pcplf), .jr_in(jr_in), .jr_bpu(jr_bpu),
		.pc_en(pc_en), .trgt_gen(trgt_gen), .b_eval(b_eval),
		.branch_outcome(branch_outcome), .npc(npc), .chng2nop(chng2nop), .mux_sel(mux_sel)
	);

	decode_stage u_decode (
		.clk(clk), .nrst(nrst), .pc_en(pc_en), .chng2nop(chng2nop), .pc(pc),
		.instr(imem_data), .cc(cc), .issue(issue), .alupc(alupc), .jr_in(jr_in),
		.trgt_gen(trgt_gen), .b_eval(b_eval), .branch_outcome(branch_outcome),
		.jr_bpu(jr_bpu)
	);

	// Flushes are the slots the BPU kills
	fe_counters #(.cnt_width(cnt_width)) u_counters (
		.clk(clk), .nrst(nrst), .pc_en(pc_en), .issue_valid(issue.valid),
		.flush(chng2nop), .issue_count(issue_count), .flush_count(flush_count)
	);

endmodule

// File: sim/tb_fetch_asserts.sv
module tb_fetch_asserts import fe_pkg::*; (
	input logic clk,                             // Clock of the front end
	input logic nrst,                            // Synchronous reset, active low
	input logic stall,                           // Front end freeze
	input logic chng2nop,                        // Word fetched now is killed
	input logic [pc_size-1:0] imem_addr,         // Fetch address
	input issue_t issue                          // Issue port
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;                          // Read by the testbench at the end

	// A reset edge leaves an empty issue slot
	a_reset_clears_issue: assert property (@(posedge clk) !nrst |=> !issue.valid)
		else begin
			fail_count++;
			$error("Issue slot valid in the cycle after reset");
		end

	// The wrong-path slot comes out with its valid bit low
	a_killed_slot_hidden: assert property (@(posedge clk) disable iff (!nrst)
		chng2nop |=> !issue.valid)
		else begin
			fail_count++;
			$error("Killed fetch slot reached the issue port");
		end

	a_stall_holds: assert property (@(posedge clk) disable iff (!nrst)
		stall |=> ($stable(imem_addr) && $stable(issue)))
		else begin
			fail_count++;
			$error("Fetch address or issue slot moved during a stall");
		end

	a_word_aligned: assert property (@(posedge clk) disable iff (!nrst) imem_addr[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("Fetch address not word aligned");
		end

endmodule

bind fetch_top tb_fetch_asserts u_asserts (
	.clk(clk), .nrst(nrst), .stall(stall), .chng2nop(chng2nop),
	.imem_addr(imem_addr), .issue(issue)
);

// File: sim/tb_fetch.sv
module tb_fetch import fe_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int table_size = 16;                  // Small table so that two PCs can alias
	localparam int cnt_width = 16;                   // Width of the DUT statistics counters
	localparam int mem_words = 256;                  // Instruction memory of 1 KB
	localparam int n_cases = 7;                      // Rows in the test table

	logic clk = 1'b0;                                // Free running clock
	logic nrst;                                      // Synchronous reset, active low
	logic stall;                                     // Front end freeze
	logic [pc_size-1:0] imem_addr;                   // Fetch address from the DUT
	logic [instr_size-1:0] imem_data;                // Word returned in the same cycle
	logic [3:0] cc;                                  // Condition flags
	issue_t issue;                                   // Issue port of the DUT
	logic [cnt_width-1:0] issue_count;               // Issued instructions
	logic [cnt_width-1:0] flush_count;               // Killed fetch slots

	logic [instr_size-1:0] imem [mem_words];         // Program image of the running case
	issue_t golden_q [$];                            // Expected issue stream
	int golden_jrs;                                  // Returns on the golden path
	int golden_nt;                                   // Not-taken branches on the golden path

	// Test table with one row per case
	string case_name [n_cases];                      // Printed in every error line
	int case_prog [n_cases];                         // Program image number
	logic [3:0] case_cc [n_cases];                   // Flags held during the case
	bit case_stall [n_cases];                        // Random stalls on or off
	int case_steps [n_cases];                        // Length of the golden path
	int case_flush [n_cases];                        // Allowed flushes besides returns and exits

	fetch_top #(.table_size(table_size), .cnt_width(cnt_width)) u_fetch_top (
		.clk(clk), .nrst(nrst), .stall(stall), .imem_addr(imem_addr),
		.imem_data(imem_data), .cc(cc), .issue(issue), .issue_count(issue_count),
		.flush_count(flush_count)
	);

	always #4 clk = ~clk;                            // 8 ns period

	assign imem_data = imem[imem_addr[9:2]];         // Single-cycle instruction memory

	// Plain instruction whose low bits follow the full address
	function automatic logic [instr_size-1:0] fill_word(input logic [pc_size-1:0] addr);
		return {op_alu, addr[25:0] ^ {20'h0, addr[31:26]}};
	endfunction

	function automatic logic [instr_size-1:0] enc_br(input logic [1:0] flag, input int off);
		return {op_br, flag, 8'h00, off[15:0]};      // Offset counts words after PC plus 4
	endfunction

	function automatic logic [instr_size-1:0] enc_jal(input int off);
		return {op_jal, off[25:0]};
	endfunction

	function automatic logic [instr_size-1:0] enc_jr();
		return {op_jr, 26'h0};
	endfunction

	function automatic logic [instr_size-1:0] enc_nop();
		return {op_nop, 26'h0};
	endfunction

	task automatic put_word(input logic [pc_size-1:0] addr, input logic [instr_size-1:0] word);
		imem[addr[9:2]] = word;                      // Byte address to word slot
	endtask

	// Unlisted words of a program image stay plain instructions
	task automatic load_program(input int prog);
		for (int i = 0; i < mem_words; i++) begin
			imem[i] = fill_word(32'(i * 4));
		end
		case (prog)
			1: begin                                 // Loop of three words closed at 8
				put_word(32'h04, enc_nop());
				put_word(32'h08, enc_br(2'd0, -3));
			end
			2: begin                                 // Call loop with a subroutine at 40
				put_word(32'h04, enc_jal(8));
				put_word(32'h08, enc_br(2'd1, -2));
				put_word(32'h30, enc_jr());
			end
			3: begin                                 // Branches at 8 and 72 share one entry
				put_word(32'h08, enc_br(2'd1, 14));
				put_word(32'h48, enc_br(2'd0, 5));
				put_word(32'h4c, enc_jal(-20));
			end
			default: begin
			end
		endcase
	endtask

	// Architectural walk of the loaded program
	task automatic build_golden(input logic [3:0] flags, input int steps);
		logic [pc_size-1:0] pc;
		logic [pc_size-1:0] link;
		logic [instr_size-1:0] word;
		logic [opcode_size-1:0] opc;
		pc = '0;
		link = '0;                                   // Link register starts at 0
		golden_q = {};
		golden_jrs = 0;
		golden_nt = 0;
		for (int s = 0; s < steps; s++) begin
			word = imem[pc[9:2]];
			golden_q.push_back('{valid: 1'b1, pc: pc, instr: word});
			opc = word[31:26];
			if (opc == op_br && flags[word[25:24]]) begin
				pc = pc + 32'd4 + {{14{word[15]}}, word[15:0], 2'b00};
			end else if (opc == op_br) begin
				pc = pc + 32'd4;                     // Falls through
				golden_nt++;
			end else if (opc == op_jal) begin
				link = pc + 32'd4;
				pc = pc + 32'd4 + {{4{word[25]}}, word[25:0], 2'b00};
			end else if (opc == op_jr) begin
				pc = link;
				golden_jrs++;
			end else begin
				pc = pc + 32'd4;
			end
		end
	endtask

	task automatic check_issue(input string what, input issue_t exp, input issue_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected valid=%0b pc=%h instr=%h actual valid=%0b pc=%h instr=%h",
				what, exp.valid, exp.pc, exp.instr, act.valid, act.pc, act.instr);
			$display("TEST FAIL");
			$fatal(1, "Issue slot differs from the golden path");
		end
	endtask

	// With at_most set the expected value is an upper bound
	task automatic check_count(input string what, input logic [cnt_width-1:0] exp,
			input logic [cnt_width-1:0] act, input bit at_most);
		if (at_most ? (act > exp) : (act !== exp)) begin
			$display("MISMATCH %s expected %s%0d actual %0d", what, at_most ? "<= " : "", exp, act);
			$display("TEST FAIL");
			$fatal(1, "Counter value out of range");
		end
	endtask

	task automatic watchdog(input longint limit_ns);
		#(limit_ns);
		$display("Watchdog expired after %0d ns, the run hung", limit_ns);
		$display("TEST FAIL");
		$fatal(1, "Timeout");
	endtask

	task automatic add_case(input int idx, input string name, input int prog,
			input logic [3:0] flags, input bit stalls, input int steps, input int flush_base);
		case_name[idx] = name;
		case_prog[idx] = prog;
		case_cc[idx] = flags;
		case_stall[idx] = stalls;
		case_steps[idx] = steps;
		case_flush[idx] = flush_base;
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic apply_reset(input logic [3:0] flags);
		nrst = 1'b0;
		stall = 1'b0;
		cc = flags;
		repeat (2) @(posedge clk);
		#1;
		nrst = 1'b1;
	endtask

	task automatic run_case(input int c);
		int n;
		int bound;
		load_program(case_prog[c]);
		build_golden(case_cc[c], case_steps[c]);
		apply_reset(case_cc[c]);
		n = 0;
		while (n < case_steps[c]) begin
			stall = case_stall[c] ? ($urandom_range(3) == 0) : 1'b0;
			@(negedge clk);
			if (issue.valid && !stall) begin        // A stalled slot is taken once it moves on
				check_issue($sformatf("%s slot %0d", case_name[c], n), golden_q[n], issue);
				n++;
			end
			@(posedge clk);
			#1;
		end
		stall = 1'b0;
		@(negedge clk);                              // Counters now include the last slot
		check_count({case_name[c], " issue_count"}, cnt_width'(case_steps[c]), issue_count, 1'b0);
		if (case_flush[c] >= 0) begin
			bound = case_flush[c] + golden_jrs + golden_nt;
			check_count({case_name[c], " flush_count"}, cnt_width'(bound), flush_count, 1'b1);
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		longint limit_ns;
		int total;
		nrst = 1'b0;
		stall = 1'b0;
		cc = 4'h0;
		load_program(0);                             // Memory answers with known words from the start
		void'($urandom(32'ha9e7_65b8));
		add_case(0, "straight", 0, 4'b0000, 1'b0, 24, 0);
		add_case(1, "loop_taken", 1, 4'b0001, 1'b0, 40, 2);
		add_case(2, "loop_exit", 1, 4'b1110, 1'b0, 20, 2);
		add_case(3, "calls", 2, 4'b0010, 1'b0, 24, 2);
		add_case(4, "alias", 3, 4'b0010, 1'b0, 30, -1);
		add_case(5, "loop_stall", 1, 4'b0001, 1'b1, 40, 2);
		add_case(6, "calls_stall", 2, 4'b0010, 1'b1, 24, 2);
		total = 0;
		for (int i = 0; i < n_cases; i++) begin
			total += case_steps[i];
		end
		limit_ns = longint'(total) * 4 * 8;          // Four cycles of 8 ns per step
		fork
			watchdog(limit_ns);
		join_none
		@(posedge clk);
		#1;
		for (int i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		if (u_fetch_top.u_asserts.fail_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("%0d assertion failures in the run", u_fetch_top.u_asserts.fail_count);
			$display("TEST FAIL");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

// File: filelist.f
verilog/fe_pkg.sv
verilog/pc_gen.sv
verilog/bpu.sv
verilog/decode_stage.sv
verilog/fe_counters.sv
verilog/fetch_top.sv
sim/tb_fetch_asserts.sv
sim/tb_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the front-end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_fetch -f filelist.f

sim_out=$(./obj_dir/Vtb_fetch 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
